// ==== hdl/aud_settings.svh ====
`ifndef AUD_SETTINGS_SVH
`define AUD_SETTINGS_SVH

// sample and sram widths
`define AUD_SAMPLE_W 16
`define AUD_ADDR_W 20

// speed factor runs 1 to 8
`define AUD_SPEED_MAX 8

// apb byte offsets
`define AUD_REG_CTRL 4'h0
`define AUD_REG_LEN 4'h4
`define AUD_REG_CMD 4'h8
`define AUD_REG_STATUS 4'hC

`endif

// ==== hdl/aud_pkg.sv ====
`default_nettype none

`include "aud_settings.svh"

package aud_pkg;

	typedef enum logic [1:0] {
		MODE_FAST   = 2'd0,
		MODE_HOLD   = 2'd1,
		MODE_LINEAR = 2'd2
	} play_mode_e;

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_FETCH = 3'd1,
		ST_SEND  = 3'd2
	} dsp_state_e;

	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;
	typedef logic [`AUD_ADDR_W-1:0] sram_addr_t;
	typedef logic [3:0] speed_t;

endpackage

`default_nettype wire

// ==== hdl/play_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface play_ctrl_if import aud_pkg::*; ();

	// commands and setup
	logic       start;
	logic       stop;
	logic       pause;
	play_mode_e mode;
	speed_t     speed;
	sram_addr_t length;

	// status back from the engine
	logic       busy;
	logic       done;

	modport regs (
		output start, stop, pause, mode, speed, length,
		input  busy, done
	);

	modport dsp (
		input  start, stop, mode, speed, length,
		output busy, done
	);

endinterface

`default_nettype wire

// ==== hdl/aud_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_apb_regs import aud_pkg::*; (
	input  wire logic        i_clk,
	input  wire logic        i_rst_n,
	input  wire logic        i_psel,
	input  wire logic        i_penable,
	input  wire logic        i_pwrite,
	input  wire logic [3:0]  i_paddr,
	input  wire logic [31:0] i_pwdata,
	output logic [31:0]      o_prdata,
	output logic             o_pready,
	output logic             o_pslverr,
	play_ctrl_if.regs        ctrl
);

	play_mode_e mode_r;
	speed_t     speed_r;
	speed_t     wr_speed;
	sram_addr_t len_r;
	logic       start_r;
	logic       stop_r;
	logic       pause_r;
	logic       done_r;
	logic       stopped_r;
	logic       stop_seen_r;
	logic       access;
	logic       addr_ok;
	logic       cfg_busy;
	logic       wr_en;

	assign access = i_psel && i_penable;
	assign addr_ok = (i_paddr == `AUD_REG_CTRL) || (i_paddr == `AUD_REG_LEN) ||
		(i_paddr == `AUD_REG_CMD) || (i_paddr == `AUD_REG_STATUS);
	// setup is frozen while a run is in progress
	assign cfg_busy = i_pwrite && ctrl.busy &&
		((i_paddr == `AUD_REG_CTRL) || (i_paddr == `AUD_REG_LEN));
	assign o_pslverr = access && (!addr_ok || cfg_busy);
	assign o_pready = 1'b1;
	assign wr_en = access && i_pwrite && !o_pslverr;

	// clamp speed into 1..max
	always_comb begin
		wr_speed = speed_t'(i_pwdata[7:4]);
		if (wr_speed == '0)
			wr_speed = speed_t'(1);
		else if (wr_speed > speed_t'(`AUD_SPEED_MAX))
			wr_speed = speed_t'(`AUD_SPEED_MAX);
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			mode_r <= MODE_FAST;
			speed_r <= speed_t'(1);
			len_r <= '0;
			start_r <= 1'b0;
			stop_r <= 1'b0;
			pause_r <= 1'b0;
			done_r <= 1'b0;
			stopped_r <= 1'b0;
			stop_seen_r <= 1'b0;
		end else begin
			start_r <= 1'b0;
			stop_r <= 1'b0;
			if (wr_en) begin
				case (i_paddr)
					`AUD_REG_CTRL: begin
						mode_r <= play_mode_e'(i_pwdata[1:0]);
						speed_r <= wr_speed;
					end
					`AUD_REG_LEN: len_r <= i_pwdata[`AUD_ADDR_W-1:0];
					`AUD_REG_CMD: begin
						// stop wins over start in one write
						stop_r <= i_pwdata[1];
						start_r <= i_pwdata[0] && !i_pwdata[1] && !ctrl.busy;
						if (i_pwdata[1] || i_pwdata[3])
							pause_r <= 1'b0;
						else if (i_pwdata[2])
							pause_r <= 1'b1;
					end
					default: ;
				endcase
			end
			if (start_r) begin
				done_r <= 1'b0;
				stopped_r <= 1'b0;
				stop_seen_r <= 1'b0;
			end else begin
				if (stop_r)
					stop_seen_r <= 1'b1;
				if (ctrl.done)
					done_r <= 1'b1;
				if (ctrl.done && (stop_seen_r || stop_r))
					stopped_r <= 1'b1;
			end
		end
	end

	always_comb begin
		o_prdata = '0;
		case (i_paddr)
			`AUD_REG_CTRL: o_prdata = {24'd0, speed_r, 2'd0, mode_r};
			`AUD_REG_LEN: o_prdata[`AUD_ADDR_W-1:0] = len_r;
			`AUD_REG_STATUS: o_prdata[2:0] = {stopped_r, done_r, ctrl.busy};
			default: o_prdata = '0;
		endcase
	end

	assign ctrl.start = start_r;
	assign ctrl.stop = stop_r;
	assign ctrl.pause = pause_r;
	assign ctrl.mode = mode_r;
	assign ctrl.speed = speed_r;
	assign ctrl.length = len_r;

	assert property (@(posedge i_clk) disable iff (!i_rst_n) !(start_r && stop_r))
		else $error("start and stop pulsed together");

endmodule

`default_nettype wire

// ==== hdl/aud_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_dsp import aud_pkg::*; (
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	play_ctrl_if.dsp     ctrl,
	input  wire sample_t i_sram_data,
	output sram_addr_t   o_sram_addr,
	output logic         o_send_en,
	output sample_t      o_send_data,
	input  wire logic    i_sent
);

	localparam int CNT_W = `AUD_ADDR_W + 4;

	dsp_state_e             state_r;
	play_mode_e             mode_r;
	speed_t                 speed_r;
	sram_addr_t             len_r;
	sram_addr_t             addr_r;
	speed_t                 phase_r;
	logic [1:0]             fetch_r;
	logic [CNT_W-1:0]       cnt_r;
	logic [CNT_W-1:0]       total_slow;
	logic [`AUD_ADDR_W:0]   next_fast;
	logic                   at_end;
	logic                   run_last;
	sample_t                pair_lo_r;
	sample_t                pair_hi_r;
	sample_t                diff;
	sample_t                step;
	sample_t                send_data_r;
	logic                   send_en_r;
	logic                   busy_r;
	logic                   done_r;

	// slow modes give (n-1)*s+1 samples
	assign total_slow = CNT_W'(len_r - 1'b1) * CNT_W'(speed_r) + 1'b1;
	assign next_fast = {1'b0, addr_r} + speed_r;
	assign at_end = (addr_r == len_r - 1'b1);
	assign run_last = (mode_r == MODE_FAST) ? (next_fast >= {1'b0, len_r}) :
		(cnt_r == total_slow);

	// wrapped difference, quotient truncates toward zero
	assign diff = pair_hi_r - pair_lo_r;
	assign step = diff / $signed({1'b0, speed_r});

	// second fetch cycle reads the upper neighbour
	assign o_sram_addr = (state_r == ST_FETCH && fetch_r == 2'd1 && !at_end) ?
		addr_r + 1'b1 : addr_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= ST_IDLE;
			mode_r <= MODE_FAST;
			speed_r <= speed_t'(1);
			len_r <= '0;
			addr_r <= '0;
			phase_r <= '0;
			fetch_r <= '0;
			cnt_r <= '0;
			send_en_r <= 1'b0;
			busy_r <= 1'b0;
			done_r <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state_r)
				ST_IDLE: begin
					if (ctrl.start) begin
						mode_r <= ctrl.mode;
						speed_r <= ctrl.speed;
						len_r <= ctrl.length;
						addr_r <= '0;
						phase_r <= '0;
						fetch_r <= '0;
						cnt_r <= '0;
						// empty record finishes at once
						if (ctrl.length == '0) begin
							done_r <= 1'b1;
						end else begin
							busy_r <= 1'b1;
							state_r <= ST_FETCH;
						end
					end
				end
				ST_FETCH: begin
					if (mode_r == MODE_FAST || fetch_r == 2'd2) begin
						fetch_r <= '0;
						send_en_r <= 1'b1;
						cnt_r <= cnt_r + 1'b1;
						state_r <= ST_SEND;
					end else begin
						fetch_r <= fetch_r + 1'b1;
					end
				end
				ST_SEND: begin
					if (i_sent) begin
						send_en_r <= 1'b0;
						if (run_last) begin
							busy_r <= 1'b0;
							done_r <= 1'b1;
							state_r <= ST_IDLE;
						end else begin
							state_r <= ST_FETCH;
							if (mode_r == MODE_FAST) begin
								addr_r <= next_fast[`AUD_ADDR_W-1:0];
							end else if (phase_r == speed_r - 1'b1) begin
								phase_r <= '0;
								addr_r <= addr_r + 1'b1;
							end else begin
								phase_r <= phase_r + 1'b1;
							end
						end
					end
				end
				default: state_r <= ST_IDLE;
			endcase
			// stop overrides the run
			if (ctrl.stop && state_r != ST_IDLE) begin
				state_r <= ST_IDLE;
				busy_r <= 1'b0;
				send_en_r <= 1'b0;
				fetch_r <= '0;
				done_r <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == ST_FETCH) begin
			if (fetch_r == 2'd0)
				pair_lo_r <= i_sram_data;
			if (fetch_r == 2'd1)
				pair_hi_r <= i_sram_data;
			if (mode_r == MODE_FAST) begin
				send_data_r <= i_sram_data;
			end else if (fetch_r == 2'd2) begin
				// linear builds on the previous sample
				if (mode_r == MODE_HOLD || phase_r == '0)
					send_data_r <= pair_lo_r;
				else
					send_data_r <= send_data_r + step;
			end
		end
	end

	assign o_send_en = send_en_r;
	assign o_send_data = send_data_r;
	assign ctrl.busy = busy_r;
	assign ctrl.done = done_r;

	assert property (@(posedge i_clk) disable iff (!i_rst_n) busy_r |-> o_sram_addr < len_r)
		else $error("sram address past record length");

	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_send_en && !i_sent |=> $stable(o_send_data))
		else $error("send data changed before sent");

	assert property (@(posedge i_clk) disable iff (!i_rst_n) busy_r |-> speed_r != '0)
		else $error("zero speed latched");

endmodule

`default_nettype wire

// ==== hdl/aud_player.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_player import aud_pkg::*; (
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_daclrck,
	input  wire logic    i_pause,
	input  wire logic    i_send_en,
	input  wire sample_t i_send_data,
	output logic         o_sent,
	output logic         o_dacdat
);

	localparam int BIT_W = $clog2(`AUD_SAMPLE_W);

	logic             lrck_q;
	logic             lrck_rise;
	logic             load;
	logic             active_r;
	logic             sent_r;
	logic [BIT_W-1:0] bit_cnt_r;
	sample_t          shift_r;

	assign lrck_rise = i_daclrck && !lrck_q;
	// send_en is still high in the sent cycle
	assign load = lrck_rise && i_send_en && !i_pause && !active_r && !sent_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			lrck_q <= 1'b0;
			active_r <= 1'b0;
			sent_r <= 1'b0;
			bit_cnt_r <= '0;
		end else begin
			lrck_q <= i_daclrck;
			sent_r <= 1'b0;
			if (load) begin
				active_r <= 1'b1;
				bit_cnt_r <= '0;
			end else if (active_r) begin
				bit_cnt_r <= bit_cnt_r + 1'b1;
				if (bit_cnt_r == BIT_W'(`AUD_SAMPLE_W - 1)) begin
					active_r <= 1'b0;
					sent_r <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (load)
			shift_r <= i_send_data;
		else if (active_r)
			shift_r <= {shift_r[`AUD_SAMPLE_W-2:0], 1'b0};
	end

	// msb first, low when idle
	assign o_dacdat = active_r && shift_r[`AUD_SAMPLE_W-1];
	assign o_sent = sent_r;

	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_sent |=> !o_sent)
		else $error("sent held for two cycles");

endmodule

`default_nettype wire

// ==== hdl/aud_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_top import aud_pkg::*; (
	input  wire logic        i_clk,
	input  wire logic        i_rst_n,
	input  wire logic        i_psel,
	input  wire logic        i_penable,
	input  wire logic        i_pwrite,
	input  wire logic [3:0]  i_paddr,
	input  wire logic [31:0] i_pwdata,
	output logic [31:0]      o_prdata,
	output logic             o_pready,
	output logic             o_pslverr,
	input  wire logic        i_daclrck,
	input  wire sample_t     i_sram_data,
	output sram_addr_t       o_sram_addr,
	output logic             o_dacdat
);

	// dsp to player handshake
	logic    send_en;
	sample_t send_data;
	logic    sent;

	play_ctrl_if ctrl ();

	aud_apb_regs regs_i (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.ctrl      (ctrl.regs)
	);

	aud_dsp dsp_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.ctrl        (ctrl.dsp),
		.i_sram_data (i_sram_data),
		.o_sram_addr (o_sram_addr),
		.o_send_en   (send_en),
		.o_send_data (send_data),
		.i_sent      (sent)
	);

	aud_player player_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_daclrck   (i_daclrck),
		.i_pause     (ctrl.pause),
		.i_send_en   (send_en),
		.i_send_data (send_data),
		.o_sent      (sent),
		.o_dacdat    (o_dacdat)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic o_clk,
	output logic o_rst_n
);

	// 40 ns period
	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (4) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/aud_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aud_settings.svh"

module aud_tb import aud_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        daclrck = 1'b0;
	sample_t     sram_data;
	sram_addr_t  sram_addr;
	logic        dacdat;

	sample_t     mem [0:63];
	sample_t     exp_q [$];
	sample_t     got_q [$];
	logic [15:0] window;
	int          lrck_cnt = 0;
	int          err_cnt = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          t_mode [$];
	int          t_speed [$];
	int          t_len [$];
	int          t_pause [$];
	int          t_stop [$];
	int          t_cnt [$];

	tb_clock clock_i (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	aud_top aud_top_i (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_psel      (psel),
		.i_penable   (penable),
		.i_pwrite    (pwrite),
		.i_paddr     (paddr),
		.i_pwdata    (pwdata),
		.o_prdata    (prdata),
		.o_pready    (pready),
		.o_pslverr   (pslverr),
		.i_daclrck   (daclrck),
		.i_sram_data (sram_data),
		.o_sram_addr (sram_addr),
		.o_dacdat    (dacdat)
	);

	// combinational sram model
	assign sram_data = (sram_addr < 64) ? mem[sram_addr[5:0]] : '0;

	// codec frame clock toggles every 20 clocks
	always @(posedge clk) begin
		if (lrck_cnt == 19) begin
			lrck_cnt <= 0;
			daclrck <= ~daclrck;
		end else begin
			lrck_cnt <= lrck_cnt + 1;
		end
	end

	// reassemble serial samples at the player's sent pulse
	always @(negedge clk) begin
		if (aud_top_i.sent)
			got_q.push_back(sample_t'(window));
		window = {window[14:0], dacdat};
	end

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_sample(input int idx, input sample_t exp, input sample_t act);
		if (exp !== act) begin
			$display("mismatch at %0t: sample %0d expected %0d got %0d", $time, idx, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_status(input logic [2:0] exp, input logic [2:0] act);
		if (exp !== act) begin
			$display("mismatch at %0t: status expected %b got %b", $time, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		check_flag("pready on write", 1'b1, pready);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		check_flag("pready on read", 1'b1, pready);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// reference sequence from the playback rules
	task automatic build_expected(input int mode, input int s, input int n);
		int      k;
		int      j;
		int      step;
		sample_t d;
		exp_q.delete();
		if (n == 0)
			return;
		if (mode == 0) begin
			for (k = 0; k < n; k += s)
				exp_q.push_back(mem[k]);
			return;
		end
		for (k = 0; k < n - 1; k++) begin
			d = mem[k+1] - mem[k];
			step = int'(d) / s;
			for (j = 0; j < s; j++) begin
				if (mode == 1)
					exp_q.push_back(mem[k]);
				else
					exp_q.push_back(sample_t'(int'(mem[k]) + j * step));
			end
		end
		exp_q.push_back(mem[n-1]);
	endtask

	task automatic read_tests();
		int    fd;
		string line;
		int    m;
		int    s;
		int    l;
		int    p;
		int    st;
		int    c;
		fd = $fopen("testbench/aud_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/aud_tests.txt");
			err_cnt++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%d %d %d %d %d %d", m, s, l, p, st, c) == 6) begin
				t_mode.push_back(m);
				t_speed.push_back(s);
				t_len.push_back(l);
				t_pause.push_back(p);
				t_stop.push_back(st);
				t_cnt.push_back(c);
			end
		end
		$fclose(fd);
		if (t_mode.size() == 0) begin
			$display("no tests found in testbench/aud_tests.txt");
			err_cnt++;
		end
	endtask

	task automatic run_test(input int t);
		logic        err;
		logic [31:0] rd;
		int          errs_before;
		int          i;
		int          held;
		errs_before = err_cnt;
		build_expected(t_mode[t], t_speed[t], t_len[t]);
		got_q.delete();
		apb_write(`AUD_REG_CTRL, {24'd0, 4'(t_speed[t]), 2'd0, 2'(t_mode[t])}, err);
		check_flag("pslverr on CTRL write", 1'b0, err);
		apb_write(`AUD_REG_LEN, 32'(t_len[t]), err);
		check_flag("pslverr on LEN write", 1'b0, err);
		apb_write(`AUD_REG_CMD, 32'h1, err);
		while (got_q.size() < 1)
			@(posedge clk);
		// setup is locked while a run is busy
		apb_write(`AUD_REG_CTRL, 32'h0000_0082, err);
		check_flag("pslverr on CTRL write while busy", 1'b1, err);
		apb_read(4'h2, rd, err);
		check_flag("pslverr on unmapped read", 1'b1, err);
		if (t_pause[t] > 0) begin
			apb_write(`AUD_REG_CMD, 32'h4, err);
			// a sample already shifting may still finish
			repeat (40) @(posedge clk);
			held = got_q.size();
			repeat (t_pause[t] - 40) @(posedge clk);
			check_count("samples while paused", held, got_q.size());
			apb_write(`AUD_REG_CMD, 32'h8, err);
		end
		if (t_stop[t] > 0) begin
			while (got_q.size() < t_stop[t])
				@(posedge clk);
			apb_write(`AUD_REG_CMD, 32'h2, err);
		end
		do
			apb_read(`AUD_REG_STATUS, rd, err);
		while (!rd[1]);
		check_count("sample count", t_cnt[t], got_q.size());
		if (t_stop[t] == 0)
			check_count("rule length", t_cnt[t], exp_q.size());
		for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
			check_sample(i, exp_q[i], got_q[i]);
		check_status((t_stop[t] > 0) ? 3'b110 : 3'b010, rd[2:0]);
		if (err_cnt == errs_before)
			pass_cnt++;
		else
			fail_cnt++;
		$display("test %0d mode %0d speed %0d length %0d samples %0d: %s", t, t_mode[t],
			t_speed[t], t_len[t], got_q.size(), (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		int unsigned seed;
		int          limit;
		int          t;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		window = '0;
		seed = 40698;
		for (int a = 0; a < 64; a++) begin
			seed = lcg_next(seed);
			mem[a] = sample_t'(seed[30:15]);
		end
		read_tests();
		// one lrck frame of 40 clocks per sample plus slack
		limit = 100;
		for (t = 0; t < t_cnt.size(); t++)
			limit += t_cnt[t] * 40 + t_pause[t] + 200;
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("watchdog expired after %0d clock cycles, run did not finish", limit);
				$display("Errors found");
				$finish;
			end
		join_none
		while (!rst_n)
			@(posedge clk);
		repeat (2) @(posedge clk);
		for (t = 0; t < t_cnt.size(); t++)
			run_test(t);
		$display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/aud_tests.txt ====
# mode speed length pause_cycles stop_after expected_count
# mode 0 fast, 1 hold, 2 linear; a zero pause or stop column means none
0 1 12 0 0 12
0 2 12 0 0 6
0 5 23 0 0 5
1 2 6 0 0 11
1 8 4 0 0 25
2 3 6 0 0 16
2 4 5 0 0 17
2 3 6 300 0 16
1 2 6 150 0 11
0 1 30 0 5 5
2 4 8 0 6 6

// ==== aud_playback.f ====
+incdir+hdl
hdl/aud_pkg.sv
hdl/play_ctrl_if.sv
hdl/aud_apb_regs.sv
hdl/aud_dsp.sv
hdl/aud_player.sv
hdl/aud_top.sv
testbench/tb_clock.sv
testbench/aud_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = aud_tb
FILELIST   = aud_playback.f
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
